// ==== tb/iq_input.mem ====
// Columns in hex: id wen wthr wmask rthr take exc ethr exp_stall exp_avail.
// One record per cycle; the id is the test number and groups records into tests.
02 1 0 1 0 0 0 0 0 0
02 1 0 3 0 0 0 0 0 1
02 1 0 7 0 0 0 0 0 7
02 1 0 f 0 0 0 0 0 7
02 0 0 0 0 0 0 0 0 7
03 0 0 0 0 1 0 0 0 7
03 0 0 0 0 3 0 0 0 7
03 0 0 0 0 7 0 0 0 7
03 0 0 0 0 7 0 0 0 7
03 1 0 f 0 1 0 0 0 1
03 1 0 f 0 3 0 0 0 7
03 0 0 0 0 7 0 0 0 7
03 0 0 0 0 7 0 0 0 7
03 0 0 0 0 0 0 0 0 0
04 1 1 f 0 0 0 0 0 0
04 1 0 3 0 0 0 0 0 0
04 1 1 7 0 0 0 0 0 3
04 0 0 0 1 0 0 0 0 3
04 0 0 0 1 3 0 0 0 7
04 0 0 0 0 0 0 0 0 7
04 0 0 0 0 1 0 0 0 3
04 0 0 0 0 0 0 0 0 1
05 1 0 f 0 0 0 0 0 1
05 1 0 f 0 0 0 0 0 7
05 1 0 f 0 0 0 0 0 7
05 1 0 f 0 0 0 0 1 7
05 1 0 1 0 0 0 0 1 7
05 1 1 f 0 0 0 0 0 7
05 1 0 f 0 1 0 0 1 7
05 1 0 f 0 0 0 0 0 7
05 0 0 0 0 7 0 0 1 7
05 0 0 0 0 7 0 0 1 7
05 0 0 0 0 0 0 0 0 7
06 0 0 0 0 0 1 0 0 7
06 0 0 0 1 0 0 0 0 0
06 0 0 0 1 0 0 0 0 7
06 1 1 f 1 7 1 1 0 7
06 0 0 0 1 0 0 0 0 0
06 1 1 3 1 0 0 0 0 0
06 0 0 0 1 0 0 0 0 3

// ==== project.f ====
+incdir+src
src/iq_pkg.sv
src/iq_storage.sv
src/iq_pointers.sv
src/iq_occupancy.sv
src/instr_queue.sv
tb/tb_instr_queue.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and judge the result from the simulation log.
rm -rf obj_dir sim.log
verilator --binary --timing -f project.f --top-module tb_instr_queue \
  -Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
grep -qx "Everything OK" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb/tb_instr_queue.sv ====
// Self-checking testbench for instr_queue; replays tb/iq_input.mem one record per clock cycle.
`timescale 1ns/1ps
`include "iq_defs.svh"

module tb_instr_queue
  import iq_pkg::*;
();

  localparam int FIELDS       = 10;
  localparam int MAX_RECS     = 64;
  localparam int SWEEP_CYCLES = 2 * `IQ_DEPTH;

  // Word offsets inside one record.
  localparam int F_ID    = 0;
  localparam int F_WEN   = 1;
  localparam int F_WTHR  = 2;
  localparam int F_WMASK = 3;
  localparam int F_RTHR  = 4;
  localparam int F_TAKE  = 5;
  localparam int F_EXC   = 6;
  localparam int F_ETHR  = 7;
  localparam int F_STALL = 8;
  localparam int F_AVAIL = 9;

  logic      clk;
  logic      rst;
  logic      write_wen;
  logic      write_thread;
  wr_mask_t  write_en;
  iq_entry_t write_data [`IQ_WR_LANES];
  logic      read_thread;
  rd_mask_t  read_take;
  logic      except;
  logic      except_thread;
  logic      stall;
  rd_mask_t  read_avail;
  iq_entry_t read_data [`IQ_RD_LANES];

  logic [7:0]  ops [MAX_RECS*FIELDS];
  iq_entry_t   model_t0 [$];
  iq_entry_t   model_t1 [$];
  logic [15:0] lfsr_state;
  logic        read_thread_m; // Model copy of the registered read thread.
  int          rec_count = 0;
  int          cycle_count = 0;
  int          err_test = 0;
  int          err_total = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  instr_queue DUT (
    .clk           (clk),
    .rst           (rst),
    .write_wen     (write_wen),
    .write_thread  (write_thread),
    .write_en      (write_en),
    .write_data    (write_data),
    .read_thread   (read_thread),
    .read_take     (read_take),
    .except        (except),
    .except_thread (except_thread),
    .stall         (stall),
    .read_avail    (read_avail),
    .read_data     (read_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10]; // x^16 + x^14 + x^13 + x^11 + 1.
    return {s[14:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [39:0] got,
                             input logic [39:0] expected);
    checks++;
    if (got !== expected) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, expected);
      err_test++;
    end
  endtask

  function automatic int queue_size(input logic t);
    return (t == 1'b0) ? model_t0.size() : model_t1.size();
  endfunction

  function automatic iq_entry_t entry_at(input logic t, input int idx);
    return (t == 1'b0) ? model_t0[idx] : model_t1[idx];
  endfunction

  task automatic push_entry(input logic t, input iq_entry_t e);
    if (t == 1'b0) begin
      model_t0.push_back(e);
    end else begin
      model_t1.push_back(e);
    end
  endtask

  task automatic pop_entries(input logic t, input int n);
    for (int k = 0; k < n; k++) begin
      if (queue_size(t) == 0) begin
        $display("a record takes more entries than thread %0d holds", t);
        err_test++;
        break;
      end
      if (t == 1'b0) begin
        model_t0.delete(0);
      end else begin
        model_t1.delete(0);
      end
    end
  endtask

  task automatic flush_thread(input logic t);
    if (t == 1'b0) begin
      model_t0.delete();
    end else begin
      model_t1.delete();
    end
  endtask

  task automatic finish_test(input int id);
    tests_run++;
    if (err_test == 0) begin
      $display("test %0d passed", id);
    end else begin
      $display("test %0d failed with %0d mismatches", id, err_test);
      tests_failed++;
    end
    err_total += err_test;
    err_test = 0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Record handling
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic drive_record(input int base);
    logic [31:0] instr_bits;
    logic [31:0] other_bits;
    iq_entry_t   e;
    for (int i = 0; i < `IQ_WR_LANES; i++) begin
      e = '0;
      if (ops[base + F_WEN][0] && ops[base + F_WMASK][i]) begin
        draw_bits(`IQ_INSTR_W, instr_bits);
        draw_bits(`IQ_OTHER_W, other_bits);
        e.instr = instr_t'(instr_bits);
        e.other = other_t'(other_bits);
      end
      write_data[i] <= e;
    end
    write_wen     <= ops[base + F_WEN][0];
    write_thread  <= ops[base + F_WTHR][0];
    write_en      <= wr_mask_t'(ops[base + F_WMASK]);
    read_thread   <= ops[base + F_RTHR][0];
    read_take     <= rd_mask_t'(ops[base + F_TAKE]);
    except        <= ops[base + F_EXC][0];
    except_thread <= ops[base + F_ETHR][0];
  endtask

  task automatic compare_outputs(input int base);
    int n;
    check_value("stall", 40'(stall), 40'(ops[base + F_STALL]));
    check_value("read_avail", 40'(read_avail), 40'(ops[base + F_AVAIL]));
    n = queue_size(read_thread_m);
    if (n > `IQ_RD_LANES) begin
      n = `IQ_RD_LANES;
    end
    for (int r = 0; r < n; r++) begin
      check_value($sformatf("read_data[%0d]", r), read_data[r], entry_at(read_thread_m, r));
    end
  endtask

  // Applies what the coming rising edge does to the reference queues.
  task automatic update_model(input int base);
    logic accept;
    logic wt;
    logic et;
    logic ex;
    wt = ops[base + F_WTHR][0];
    et = ops[base + F_ETHR][0];
    ex = ops[base + F_EXC][0];
    accept = ops[base + F_WEN][0] && (queue_size(wt) <= `IQ_STALL_LIMIT);
    if (!(ex && et == read_thread_m)) begin
      pop_entries(read_thread_m, $countones(ops[base + F_TAKE]));
    end
    if (accept && !(ex && et == wt)) begin
      for (int i = 0; i < `IQ_WR_LANES; i++) begin
        if (write_en[i]) begin
          push_entry(wt, write_data[i]);
        end
      end
    end
    if (ex) begin
      flush_thread(et);
    end
    read_thread_m = ops[base + F_RTHR][0];
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int base;
    int prev_id;
    rst           <= 1'b1;
    write_wen     <= 1'b0;
    write_thread  <= 1'b0;
    write_en      <= '0;
    read_thread   <= 1'b0;
    read_take     <= '0;
    except        <= 1'b0;
    except_thread <= 1'b0;
    for (int i = 0; i < `IQ_WR_LANES; i++) begin
      write_data[i] <= '0;
    end
    read_thread_m = 1'b0;
    lfsr_state = 16'd73;
    for (int i = 0; i < MAX_RECS*FIELDS; i++) begin
      ops[i] = 8'hff; // An id of ff marks the end of the records.
    end
    $readmemh("tb/iq_input.mem", ops);
    while (rec_count < MAX_RECS && ops[rec_count*FIELDS] != 8'hff) begin
      rec_count++;
    end
    if (rec_count == 0) begin
      $display("no operation records could be read from tb/iq_input.mem");
      tests_failed++;
    end

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int k = 0; k < SWEEP_CYCLES; k++) begin
      @(negedge clk);
      check_value("stall", 40'(stall), 40'd1);
      check_value("read_avail", 40'(read_avail), 40'd0);
    end
    @(negedge clk);
    check_value("stall", 40'(stall), 40'd0); // Sweep is over.
    finish_test(1);

    prev_id = -1;
    for (int r = 0; r < rec_count; r++) begin
      base = r * FIELDS;
      if (prev_id >= 0 && int'(ops[base + F_ID]) != prev_id) begin
        finish_test(prev_id);
      end
      prev_id = int'(ops[base + F_ID]);
      @(posedge clk);
      drive_record(base);
      @(negedge clk);
      compare_outputs(base);
      update_model(base);
    end
    if (prev_id >= 0) begin
      finish_test(prev_id);
    end

    $display("tests run %0d, tests failed %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, checks, err_total);
    if (tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= SWEEP_CYCLES + rec_count + 20) begin
      $display("timeout after %0d cycles before the operation file was finished", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

endmodule

// ==== src/instr_queue.sv ====
// Top of the two-thread instruction queue between decode and rename; instantiate as the DUT.
`timescale 1ns/1ps
`include "iq_defs.svh"

module instr_queue
  import iq_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      write_wen,
  input  logic      write_thread,
  input  wr_mask_t  write_en,
  input  iq_entry_t write_data [`IQ_WR_LANES],
  input  logic      read_thread,
  input  rd_mask_t  read_take,
  input  logic      except,
  input  logic      except_thread,
  output logic      stall,
  output rd_mask_t  read_avail,
  output iq_entry_t read_data [`IQ_RD_LANES]
);

  logic   read_thread_q;
  logic   write_go;
  logic   init_busy;
  qaddr_t wr_ptr;
  qaddr_t rd_ptr;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      read_thread_q <= 1'b0;
    end else begin
      read_thread_q <= read_thread; // Read window and take both follow this copy.
    end
  end

  assign write_go = write_wen && !stall; // Writer holds the group while stalled.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Blocks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  iq_storage u_storage (
    .clk           (clk),
    .rst           (rst),
    .write_go      (write_go),
    .write_thread  (write_thread),
    .write_en      (write_en),
    .write_data    (write_data),
    .wr_ptr        (wr_ptr),
    .read_thread_q (read_thread_q),
    .rd_ptr        (rd_ptr),
    .init_busy     (init_busy),
    .read_data     (read_data)
  );

  iq_pointers u_pointers (
    .clk           (clk),
    .rst           (rst),
    .write_go      (write_go),
    .write_thread  (write_thread),
    .write_en      (write_en),
    .read_thread_q (read_thread_q),
    .read_take     (read_take),
    .except        (except),
    .except_thread (except_thread),
    .wr_ptr        (wr_ptr),
    .rd_ptr        (rd_ptr)
  );

  iq_occupancy u_occupancy (
    .clk           (clk),
    .rst           (rst),
    .write_go      (write_go),
    .write_thread  (write_thread),
    .write_en      (write_en),
    .read_thread_q (read_thread_q),
    .read_take     (read_take),
    .except        (except),
    .except_thread (except_thread),
    .init_busy     (init_busy),
    .stall         (stall),
    .read_avail    (read_avail)
  );

endmodule

// ==== src/iq_occupancy.sv ====
// Per-thread occupancy of the instruction queue; drives write stall and the read-available mask.
`timescale 1ns/1ps
`include "iq_defs.svh"

module iq_occupancy
  import iq_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     write_go,
  input  logic     write_thread,
  input  wr_mask_t write_en,
  input  logic     read_thread_q,
  input  rd_mask_t read_take,
  input  logic     except,
  input  logic     except_thread,
  input  logic     init_busy,
  output logic     stall,
  output rd_mask_t read_avail
);

  occ_t occ_q [2];
  occ_t wr_cnt;
  occ_t rd_cnt;
  occ_t rd_occ;

  assign wr_cnt = occ_t'($countones(write_en));
  assign rd_cnt = occ_t'($countones(read_take));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar t = 0; t < 2; t++) begin : g_thread
    occ_t inc;
    occ_t dec;

    assign inc = (write_go && (write_thread == 1'(t))) ? wr_cnt : '0;
    assign dec = (read_thread_q == 1'(t)) ? rd_cnt : '0;

    always_ff @(posedge clk) begin
      if (rst || (except && (except_thread == 1'(t)))) begin
        occ_q[t] <= '0;
      end else begin
        occ_q[t] <= occ_q[t] + inc - dec; // Write and take land on the same edge.
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flow control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Refuse a group unless a full one fits.
  assign stall = init_busy || (occ_q[write_thread] > occ_t'(`IQ_STALL_LIMIT));

  assign rd_occ = occ_q[read_thread_q];

  always_comb begin
    for (int r = 0; r < `IQ_RD_LANES; r++) begin
      read_avail[r] = (rd_occ > occ_t'(r)); // Thermometer, capped by the lane count.
    end
  end

endmodule

// ==== src/iq_pointers.sv ====
// Per-thread write and read pointers of the instruction queue, advanced by lane count.
`timescale 1ns/1ps
`include "iq_defs.svh"

module iq_pointers
  import iq_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     write_go,
  input  logic     write_thread,
  input  wr_mask_t write_en,
  input  logic     read_thread_q,
  input  rd_mask_t read_take,
  input  logic     except,
  input  logic     except_thread,
  output qaddr_t   wr_ptr,
  output qaddr_t   rd_ptr
);

  qaddr_t wr_ptr_q [2];
  qaddr_t rd_ptr_q [2];
  qaddr_t wr_step;
  qaddr_t rd_step;

  // Prefix masks, so the popcount is the number of lanes used.
  assign wr_step = qaddr_t'($countones(write_en));
  assign rd_step = qaddr_t'($countones(read_take));

  for (genvar t = 0; t < 2; t++) begin : g_thread
    logic flush;
    logic wr_hit;
    logic rd_hit;

    assign flush  = except && (except_thread == 1'(t));
    assign wr_hit = write_go && (write_thread == 1'(t));
    assign rd_hit = (read_thread_q == 1'(t));

    always_ff @(posedge clk) begin
      if (rst || flush) begin
        wr_ptr_q[t] <= '0; // Flush drops any same-cycle traffic on this thread.
        rd_ptr_q[t] <= '0;
      end else begin
        if (wr_hit) begin
          wr_ptr_q[t] <= wr_ptr_q[t] + wr_step;
        end
        if (rd_hit) begin
          rd_ptr_q[t] <= rd_ptr_q[t] + rd_step;
        end
      end
    end
  end

  assign wr_ptr = wr_ptr_q[write_thread];
  assign rd_ptr = rd_ptr_q[read_thread_q];

endmodule

// ==== src/iq_storage.sv ====
// Entry store of the instruction queue: lane writes, three-entry read window, clearing sweep.
`timescale 1ns/1ps
`include "iq_defs.svh"

module iq_storage
  import iq_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      write_go,
  input  logic      write_thread,
  input  wr_mask_t  write_en,
  input  iq_entry_t write_data [`IQ_WR_LANES],
  input  qaddr_t    wr_ptr,
  input  logic      read_thread_q,
  input  qaddr_t    rd_ptr,
  output logic      init_busy,
  output iq_entry_t read_data [`IQ_RD_LANES]
);

  iq_entry_t   mem [2][`IQ_DEPTH];
  qaddr_t      wr_slot [`IQ_WR_LANES];
  qaddr_t      rd_slot [`IQ_RD_LANES];
  init_state_t state_q;

  // Top bit picks the thread, the rest the slot.
  logic [`IQ_ADDR_W:0] sweep_idx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clearing sweep
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= INIT_CLEAR;
      sweep_idx <= '0;
    end else begin
      case (state_q)
        INIT_CLEAR: begin
          sweep_idx <= sweep_idx + 1'b1;
          if (&sweep_idx) begin
            state_q <= INIT_DONE; // Last slot of thread 1 is cleared this cycle.
          end
        end
        default: begin
          state_q <= INIT_DONE;
        end
      endcase
    end
  end

  assign init_busy = (state_q == INIT_CLEAR);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Slot addressing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Power-of-two depth, so the 4-bit sum wraps at the end of the store.
  always_comb begin
    for (int i = 0; i < `IQ_WR_LANES; i++) begin
      wr_slot[i] = wr_ptr + qaddr_t'(i);
    end
    for (int r = 0; r < `IQ_RD_LANES; r++) begin
      rd_slot[r] = rd_ptr + qaddr_t'(r);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Store
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (init_busy) begin
      mem[sweep_idx[`IQ_ADDR_W]][sweep_idx[`IQ_ADDR_W-1:0]] <= '0;
    end
    // The writer sees stall during the sweep, so the two never overlap.
    if (write_go) begin
      for (int i = 0; i < `IQ_WR_LANES; i++) begin
        if (write_en[i]) begin
          mem[write_thread][wr_slot[i]] <= write_data[i];
        end
      end
    end
  end

  // Oldest entries of the registered read thread.
  always_comb begin
    for (int r = 0; r < `IQ_RD_LANES; r++) begin
      read_data[r] = mem[read_thread_q][rd_slot[r]];
    end
  end

endmodule

// ==== src/iq_pkg.sv ====
// Shared vector types and the entry struct for the instruction queue; import into each queue module.
`include "iq_defs.svh"

package iq_pkg;

  // Payload fields.
  typedef logic [`IQ_INSTR_W-1:0] instr_t;
  typedef logic [`IQ_OTHER_W-1:0] other_t;

  // Index into one thread's circular store.
  typedef logic [`IQ_ADDR_W-1:0] qaddr_t;

  // Entry count of one thread.
  typedef logic [`IQ_OCC_W-1:0] occ_t;

  // Lane masks, always prefix shaped.
  typedef logic [`IQ_WR_LANES-1:0] wr_mask_t;
  typedef logic [`IQ_RD_LANES-1:0] rd_mask_t;

  // One queue slot.
  typedef struct packed {
    instr_t instr;
    other_t other;
  } iq_entry_t;

  // Post-reset clearing sweep.
  typedef enum logic {
    INIT_CLEAR,
    INIT_DONE
  } init_state_t;

endpackage

// ==== src/iq_defs.svh ====
// Sizing macros for the two-thread instruction queue; include wherever a width or depth is needed.
`ifndef IQ_DEFS_SVH
`define IQ_DEFS_SVH

// Payload widths.
`define IQ_INSTR_W 32
`define IQ_OTHER_W 8

// Lanes per cycle on each side.
`define IQ_WR_LANES 4
`define IQ_RD_LANES 3

// Per-thread store.
`define IQ_DEPTH 16
`define IQ_ADDR_W 4

// Counts 0 to IQ_DEPTH inclusive.
`define IQ_OCC_W 5

// A thread above this count cannot take a full write group.
`define IQ_STALL_LIMIT (`IQ_DEPTH - `IQ_WR_LANES)

`endif
